// ==== src/tile_config.svh ====
`ifndef TILE_CONFIG_SVH
`define TILE_CONFIG_SVH

// memory map of the tile
// each window is matched as (addr & mask) == base

// data RAM, 1 KiB window
`define TILE_RAM_BASE 32'h0010_0000
`define TILE_RAM_MASK 32'hFFFF_FC00

// RAM depth in 32-bit words, fills the whole window
`define TILE_RAM_WORDS 256

// simulation control block, 1 KiB window
`define TILE_SIMCTRL_BASE 32'h0002_0000
`define TILE_SIMCTRL_MASK 32'hFFFF_FC00

// machine timer, 1 KiB window
`define TILE_TIMER_BASE 32'h0003_0000
`define TILE_TIMER_MASK 32'hFFFF_FC00

// low address bits that pick a register inside a device
// must agree with the 1 KiB window masks above
`define TILE_OFFSET_BITS 10

`endif

// ==== src/tile_pkg.sv ====
`default_nettype none

`include "tile_config.svh"

package tile_pkg;

  // bus word types
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  // target of one bus access
  // DEV_NONE marks an address outside every window
  typedef enum logic [1:0] {
    DEV_RAM,
    DEV_SIMCTRL,
    DEV_TIMER,
    DEV_NONE
  } bus_device_e;

  // timer register byte offsets inside its window
  typedef enum logic [`TILE_OFFSET_BITS-1:0] {
    TMR_MTIME_LO    = 'h0,
    TMR_MTIME_HI    = 'h4,
    TMR_MTIMECMP_LO = 'h8,
    TMR_MTIMECMP_HI = 'hC
  } timer_reg_e;

  // sim control register byte offsets
  // 0x4 is left free
  typedef enum logic [`TILE_OFFSET_BITS-1:0] {
    SIM_CHAR_OUT = 'h0,
    SIM_HALT     = 'h8
  } simctrl_reg_e;

endpackage

`default_nettype wire

// ==== src/bus_decoder.sv ====
`default_nettype none

`include "tile_config.svh"

module bus_decoder (
  input  wire logic           req_i,
  input  wire tile_pkg::addr_t addr_i,
  output logic                ram_req_o,
  output logic                simctrl_req_o,
  output logic                timer_req_o,
  output logic                unmapped_o
);

  // window hits, independent of the request
  logic ram_hit;
  logic simctrl_hit;
  logic timer_hit;
  logic any_hit;

  // compare the address under each window mask
  assign ram_hit     = (addr_i & `TILE_RAM_MASK) == `TILE_RAM_BASE;
  assign simctrl_hit = (addr_i & `TILE_SIMCTRL_MASK) == `TILE_SIMCTRL_BASE;
  assign timer_hit   = (addr_i & `TILE_TIMER_MASK) == `TILE_TIMER_BASE;
  assign any_hit     = ram_hit | simctrl_hit | timer_hit;

  // strobes only fire while the host requests
  assign ram_req_o     = req_i & ram_hit;
  assign simctrl_req_o = req_i & simctrl_hit;
  assign timer_req_o   = req_i & timer_hit;

  // nothing matched, the router turns this into an error response
  assign unmapped_o = req_i & ~any_hit;

  // windows in the config header must not overlap,
  // otherwise two devices would see the same access
  one_target_a: assert final ($onehot0({ram_req_o, simctrl_req_o, timer_req_o, unmapped_o}));

endmodule

`default_nettype wire

// ==== src/data_ram.sv ====
`default_nettype none

`include "tile_config.svh"

module data_ram (
  input  wire logic            clk_sys,
  input  wire logic            reset_i,
  input  wire logic            req_i,
  input  wire logic            we_i,
  input  wire tile_pkg::be_t   be_i,
  input  wire tile_pkg::addr_t addr_i,
  input  wire tile_pkg::data_t wdata_i,
  output tile_pkg::data_t      rdata_o
);

  import tile_pkg::*;

  localparam int unsigned IDX_BITS = $clog2(`TILE_RAM_WORDS);

  // word array, contents undefined after reset
  data_t mem [`TILE_RAM_WORDS];

  // word select, skips the two byte offset bits
  logic [IDX_BITS-1:0] word_idx;

  assign word_idx = addr_i[IDX_BITS+1:2];

  // byte-lane writes
  always_ff @(posedge clk_sys) begin
    if (req_i && we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (be_i[b]) begin
          mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // read port, one cycle latency
  // a write answers with a zero word
  always_ff @(posedge clk_sys) begin
    if (reset_i) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= we_i ? '0 : mem[word_idx];
    end
  end

endmodule

`default_nettype wire

// ==== src/mtimer.sv ====
`default_nettype none

`include "tile_config.svh"

module mtimer (
  input  wire logic            clk_sys,
  input  wire logic            reset_i,
  input  wire logic            req_i,
  input  wire logic            we_i,
  input  wire tile_pkg::addr_t addr_i,
  input  wire tile_pkg::data_t wdata_i,
  output tile_pkg::data_t      rdata_o,
  output logic                 timer_irq_o
);

  import tile_pkg::*;

  // 64-bit time and compare values
  logic [63:0] mtime;
  logic [63:0] mtimecmp;

  // register select from the low address bits
  timer_reg_e reg_sel;
  data_t      rd_word;

  assign reg_sel = timer_reg_e'(addr_i[`TILE_OFFSET_BITS-1:0]);

  // read mux, unknown offsets read as zero
  always_comb begin
    case (reg_sel)
      TMR_MTIME_LO:    rd_word = mtime[31:0];
      TMR_MTIME_HI:    rd_word = mtime[63:32];
      TMR_MTIMECMP_LO: rd_word = mtimecmp[31:0];
      TMR_MTIMECMP_HI: rd_word = mtimecmp[63:32];
      default:         rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_sys) begin
    if (reset_i) begin
      mtime       <= '0;
      // all ones keeps the interrupt quiet until software arms it
      mtimecmp    <= '1;
      timer_irq_o <= 1'b0;
      rdata_o     <= '0;
    end else begin
      // free-running count
      mtime <= mtime + 64'd1;
      // level irq, one cycle behind the compare
      timer_irq_o <= (mtime >= mtimecmp);

      // whole-word writes, a write to mtime wins over the increment
      if (req_i && we_i) begin
        case (reg_sel)
          TMR_MTIME_LO:    mtime <= {mtime[63:32], wdata_i};
          TMR_MTIME_HI:    mtime <= {wdata_i, mtime[31:0]};
          TMR_MTIMECMP_LO: mtimecmp[31:0] <= wdata_i;
          TMR_MTIMECMP_HI: mtimecmp[63:32] <= wdata_i;
          default: ;
        endcase
      end

      // registered response word, zero for writes
      if (req_i) begin
        rdata_o <= we_i ? '0 : rd_word;
      end
    end
  end

  // the first compare out of reset must leave the interrupt low
  irq_low_after_reset_a: assert property (@(posedge clk_sys) $fell(reset_i) |=> !timer_irq_o);

endmodule

`default_nettype wire

// ==== src/sim_ctrl.sv ====
`default_nettype none

`include "tile_config.svh"

module sim_ctrl (
  input  wire logic            clk_sys,
  input  wire logic            reset_i,
  input  wire logic            req_i,
  input  wire logic            we_i,
  input  wire tile_pkg::addr_t addr_i,
  input  wire tile_pkg::data_t wdata_i,
  output tile_pkg::data_t      rdata_o,
  output logic                 char_valid_o,
  output logic [7:0]           char_data_o,
  output logic                 halt_o
);

  import tile_pkg::*;

  simctrl_reg_e reg_sel;
  logic         wr_en;

  assign reg_sel = simctrl_reg_e'(addr_i[`TILE_OFFSET_BITS-1:0]);
  assign wr_en   = req_i & we_i;

  // control block is write-only, every read returns zero
  assign rdata_o = '0;

  // char strobe lasts one cycle, halt is sticky until reset
  always_ff @(posedge clk_sys) begin
    if (reset_i) begin
      char_valid_o <= 1'b0;
      halt_o       <= 1'b0;
    end else begin
      char_valid_o <= wr_en && (reg_sel == SIM_CHAR_OUT);
      if (wr_en && (reg_sel == SIM_HALT)) begin
        halt_o <= 1'b1;
      end
    end
  end

  // character byte, only meaningful with char_valid_o
  always_ff @(posedge clk_sys) begin
    if (wr_en && (reg_sel == SIM_CHAR_OUT)) begin
      char_data_o <= wdata_i[7:0];
    end
  end

endmodule

`default_nettype wire

// ==== src/resp_router.sv ====
`default_nettype none

module resp_router (
  input  wire logic            clk_sys,
  input  wire logic            reset_i,
  input  wire logic            ram_req_i,
  input  wire logic            simctrl_req_i,
  input  wire logic            timer_req_i,
  input  wire logic            unmapped_i,
  input  wire tile_pkg::data_t ram_rdata_i,
  input  wire tile_pkg::data_t simctrl_rdata_i,
  input  wire tile_pkg::data_t timer_rdata_i,
  output logic                 rvalid_o,
  output logic                 err_o,
  output tile_pkg::data_t      rdata_o
);

  import tile_pkg::*;

  logic        accept;
  bus_device_e target_d;
  bus_device_e target_q;
  logic        rvalid_q;

  // every strobe from the decoder is an accepted access
  assign accept = ram_req_i | simctrl_req_i | timer_req_i | unmapped_i;

  // encode the strobes, unmapped falls through to DEV_NONE
  always_comb begin
    if (ram_req_i) begin
      target_d = DEV_RAM;
    end else if (simctrl_req_i) begin
      target_d = DEV_SIMCTRL;
    end else if (timer_req_i) begin
      target_d = DEV_TIMER;
    end else begin
      target_d = DEV_NONE;
    end
  end

  // one response in flight, taken over by the next accept
  always_ff @(posedge clk_sys) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
      target_q <= DEV_NONE;
    end else begin
      rvalid_q <= accept;
      if (accept) begin
        target_q <= target_d;
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = rvalid_q && (target_q == DEV_NONE);

  // device words are already registered, pick the one that was addressed
  always_comb begin
    case (target_q)
      DEV_RAM:     rdata_o = ram_rdata_i;
      DEV_SIMCTRL: rdata_o = simctrl_rdata_i;
      DEV_TIMER:   rdata_o = timer_rdata_i;
      default:     rdata_o = '0;
    endcase
  end

  // an error is always the response to an unmapped access
  err_with_rvalid_a: assert property (@(posedge clk_sys) disable iff (reset_i)
    err_o |-> rvalid_o && $past(unmapped_i));

endmodule

`default_nettype wire

// ==== src/tile_bus_top.sv ====
`default_nettype none

module tile_bus_top (
  input  wire logic            clk_sys,
  input  wire logic            reset_i,
  // host data bus
  input  wire logic            host_req_i,
  input  wire tile_pkg::addr_t host_addr_i,
  input  wire logic            host_we_i,
  input  wire tile_pkg::be_t   host_be_i,
  input  wire tile_pkg::data_t host_wdata_i,
  output logic                 host_gnt_o,
  output logic                 host_rvalid_o,
  output tile_pkg::data_t      host_rdata_o,
  output logic                 host_err_o,
  // side-band outputs of the devices
  output logic                 timer_irq_o,
  output logic                 char_valid_o,
  output logic [7:0]           char_data_o,
  output logic                 halt_o
);

  import tile_pkg::*;

  // per-device request strobes
  logic ram_req;
  logic simctrl_req;
  logic timer_req;
  logic unmapped;

  // registered read words from the devices
  data_t ram_rdata;
  data_t simctrl_rdata;
  data_t timer_rdata;

  // no wait states, every request is granted at once
  assign host_gnt_o = host_req_i;

  bus_decoder i_bus_decoder (
    .req_i         (host_req_i),
    .addr_i        (host_addr_i),
    .ram_req_o     (ram_req),
    .simctrl_req_o (simctrl_req),
    .timer_req_o   (timer_req),
    .unmapped_o    (unmapped)
  );

  // address and write data fan out to all devices
  data_ram i_data_ram (
    .clk_sys (clk_sys),
    .reset_i (reset_i),
    .req_i   (ram_req),
    .we_i    (host_we_i),
    .be_i    (host_be_i),
    .addr_i  (host_addr_i),
    .wdata_i (host_wdata_i),
    .rdata_o (ram_rdata)
  );

  mtimer i_mtimer (
    .clk_sys     (clk_sys),
    .reset_i     (reset_i),
    .req_i       (timer_req),
    .we_i        (host_we_i),
    .addr_i      (host_addr_i),
    .wdata_i     (host_wdata_i),
    .rdata_o     (timer_rdata),
    .timer_irq_o (timer_irq_o)
  );

  sim_ctrl i_sim_ctrl (
    .clk_sys      (clk_sys),
    .reset_i      (reset_i),
    .req_i        (simctrl_req),
    .we_i         (host_we_i),
    .addr_i       (host_addr_i),
    .wdata_i      (host_wdata_i),
    .rdata_o      (simctrl_rdata),
    .char_valid_o (char_valid_o),
    .char_data_o  (char_data_o),
    .halt_o       (halt_o)
  );

  resp_router i_resp_router (
    .clk_sys         (clk_sys),
    .reset_i         (reset_i),
    .ram_req_i       (ram_req),
    .simctrl_req_i   (simctrl_req),
    .timer_req_i     (timer_req),
    .unmapped_i      (unmapped),
    .ram_rdata_i     (ram_rdata),
    .simctrl_rdata_i (simctrl_rdata),
    .timer_rdata_i   (timer_rdata),
    .rvalid_o        (host_rvalid_o),
    .err_o           (host_err_o),
    .rdata_o         (host_rdata_o)
  );

endmodule

`default_nettype wire

// ==== tb/tile_bus_tb.sv ====
`default_nettype none

`include "tile_config.svh"

module tile_bus_tb;

  import tile_pkg::*;

  // how the read data of the next response is checked
  localparam logic [1:0] CHK_NONE = 2'd0;
  localparam logic [1:0] CHK_EQ   = 2'd1;
  localparam logic [1:0] CHK_GT   = 2'd2;

  localparam int    BUS_TIMEOUT   = 8;
  localparam int    IRQ_TIMEOUT   = 200;
  localparam addr_t UNMAPPED_BASE = 32'h0004_0000;

  // device register addresses
  localparam addr_t CHAR_ADDR     = `TILE_SIMCTRL_BASE | 32'(SIM_CHAR_OUT);
  localparam addr_t HALT_ADDR     = `TILE_SIMCTRL_BASE | 32'(SIM_HALT);
  localparam addr_t MTIME_LO_ADDR = `TILE_TIMER_BASE | 32'(TMR_MTIME_LO);
  localparam addr_t CMP_LO_ADDR   = `TILE_TIMER_BASE | 32'(TMR_MTIMECMP_LO);
  localparam addr_t CMP_HI_ADDR   = `TILE_TIMER_BASE | 32'(TMR_MTIMECMP_HI);

  logic       clk_sys;
  logic       reset_i;
  logic       host_req_i;
  addr_t      host_addr_i;
  logic       host_we_i;
  be_t        host_be_i;
  data_t      host_wdata_i;
  logic       host_gnt_o;
  logic       host_rvalid_o;
  data_t      host_rdata_o;
  logic       host_err_o;
  logic       timer_irq_o;
  logic       char_valid_o;
  logic [7:0] char_data_o;
  logic       halt_o;

  // expectations for the response in flight
  logic [1:0] chk_mode;
  data_t      exp_rdata;
  logic       exp_err;
  logic [7:0] exp_char;
  // interrupt must stay low while set
  logic       irq_quiet;
  int         seed;

  // reference copy of the RAM
  data_t ram_model [`TILE_RAM_WORDS];

  // writes that hit the sim control registers
  logic char_wr;
  logic halt_wr;

  assign char_wr = host_req_i && host_we_i && (host_addr_i == CHAR_ADDR);
  assign halt_wr = host_req_i && host_we_i && (host_addr_i == HALT_ADDR);

  tile_bus_top i_tile_bus_top (
    .clk_sys       (clk_sys),
    .reset_i       (reset_i),
    .host_req_i    (host_req_i),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_gnt_o    (host_gnt_o),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .timer_irq_o   (timer_irq_o),
    .char_valid_o  (char_valid_o),
    .char_data_o   (char_data_o),
    .halt_o        (halt_o)
  );

  initial begin
    clk_sys = 1'b0;
    forever #2 clk_sys = ~clk_sys;
  end

  task automatic value_error(input string msg);
    $display("error at time %0t: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic wait_expired(input string what);
    $display("timeout at time %0t: %s", $time, what);
    $display("Testbench failed");
    $fatal(1, "stopped on a timeout");
  endtask

  // only the enabled byte lanes take the new data
  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t be);
    data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // one access, held for one cycle, then wait for its response
  task automatic bus_access(input logic we, input addr_t addr, input be_t be,
                            input data_t wdata, input logic [1:0] mode,
                            input data_t exp_data, input logic err, output data_t rdata);
    int cnt;
    chk_mode  = mode;
    exp_rdata = exp_data;
    exp_err   = err;
    @(posedge clk_sys);
    host_req_i   <= 1'b1;
    host_addr_i  <= addr;
    host_we_i    <= we;
    host_be_i    <= be;
    host_wdata_i <= wdata;
    // granted at this edge
    @(posedge clk_sys);
    host_req_i <= 1'b0;
    cnt = 0;
    do begin
      @(posedge clk_sys);
      cnt++;
    end while (!host_rvalid_o && cnt < BUS_TIMEOUT);
    if (!host_rvalid_o) begin
      wait_expired("no rvalid after an accepted bus access");
    end else begin
      rdata = host_rdata_o;
    end
  endtask

  task automatic wait_irq_level(input logic level, input string what);
    int cnt;
    cnt = 0;
    while (timer_irq_o !== level && cnt < IRQ_TIMEOUT) begin
      @(posedge clk_sys);
      cnt++;
    end
    if (timer_irq_o !== level) begin
      wait_expired(what);
    end
  endtask

  // handshake
  gnt_follows_req_a: assert property (@(posedge clk_sys) host_gnt_o == host_req_i)
    else value_error("gnt differs from req");
  rvalid_after_accept_a: assert property (@(posedge clk_sys) disable iff (reset_i)
    host_req_i && host_gnt_o |=> host_rvalid_o)
    else value_error("rvalid missing one cycle after acceptance");
  rvalid_only_after_accept_a: assert property (@(posedge clk_sys) disable iff (reset_i)
    !(host_req_i && host_gnt_o) |=> !host_rvalid_o)
    else value_error("rvalid without an accepted access");
  reset_quiet_a: assert property (@(posedge clk_sys) reset_i |=>
    !host_rvalid_o && !host_err_o && !timer_irq_o && !char_valid_o && !halt_o)
    else value_error("output high right after reset");

  // response contents
  err_expected_a: assert property (@(posedge clk_sys) disable iff (reset_i)
    host_rvalid_o |-> host_err_o == exp_err)
    else value_error($sformatf("err is %b, expected %b", $sampled(host_err_o), exp_err));
  rdata_equal_a: assert property (@(posedge clk_sys) disable iff (reset_i)
    host_rvalid_o && chk_mode == CHK_EQ |-> host_rdata_o === exp_rdata)
    else value_error($sformatf("rdata %h, expected %h", $sampled(host_rdata_o), exp_rdata));
  rdata_greater_a: assert property (@(posedge clk_sys) disable iff (reset_i)
    host_rvalid_o && chk_mode == CHK_GT |-> host_rdata_o > exp_rdata)
    else value_error($sformatf("mtime %h did not pass %h", $sampled(host_rdata_o), exp_rdata));

  // timer and sim control side-band
  irq_quiet_a: assert property (@(posedge clk_sys) disable iff (reset_i)
    irq_quiet |-> !timer_irq_o)
    else value_error("timer interrupt high while mtimecmp is out of reach");
  char_pulse_a: assert property (@(posedge clk_sys) disable iff (reset_i)
    char_wr |=> char_valid_o && char_data_o == exp_char)
    else value_error("no character or wrong character after a char write");
  char_only_after_write_a: assert property (@(posedge clk_sys) disable iff (reset_i)
    !char_wr |=> !char_valid_o)
    else value_error("char_valid without a char write");
  halt_set_a: assert property (@(posedge clk_sys) disable iff (reset_i)
    halt_wr |=> halt_o)
    else value_error("halt did not rise after a halt write");
  halt_sticky_a: assert property (@(posedge clk_sys) disable iff (reset_i)
    halt_o |=> halt_o)
    else value_error("halt dropped before reset");
  halt_quiet_a: assert property (@(posedge clk_sys) disable iff (reset_i)
    !halt_o && !halt_wr |=> !halt_o)
    else value_error("halt rose without a halt write");

  initial begin : stimulus
    data_t rdata;
    data_t first_time;
    data_t now_time;
    data_t wdata;
    be_t   be;
    int    word_idx [8];
    int    k;
    seed         = 4128;
    reset_i      = 1'b1;
    host_req_i   = 1'b0;
    host_addr_i  = '0;
    host_we_i    = 1'b0;
    host_be_i    = '0;
    host_wdata_i = '0;
    chk_mode     = CHK_NONE;
    exp_rdata    = '0;
    exp_err      = 1'b0;
    exp_char     = '0;
    irq_quiet    = 1'b1;
    repeat (4) @(posedge clk_sys);
    reset_i <= 1'b0;

    // fill a few words whole, so every model byte is known
    for (int i = 0; i < 8; i++) begin
      word_idx[i] = $unsigned($random(seed)) % `TILE_RAM_WORDS;
      wdata = $random(seed);
      bus_access(1'b1, `TILE_RAM_BASE | (word_idx[i] << 2), 4'hF, wdata,
                 CHK_EQ, '0, 1'b0, rdata);
      ram_model[word_idx[i]] = wdata;
    end
    // partial writes with random lanes
    for (int i = 0; i < 24; i++) begin
      k = $unsigned($random(seed)) % 8;
      be = be_t'($random(seed));
      wdata = $random(seed);
      bus_access(1'b1, `TILE_RAM_BASE | (word_idx[k] << 2), be, wdata,
                 CHK_EQ, '0, 1'b0, rdata);
      ram_model[word_idx[k]] = merge_bytes(ram_model[word_idx[k]], wdata, be);
    end
    for (int i = 0; i < 8; i++) begin
      bus_access(1'b0, `TILE_RAM_BASE | (word_idx[i] << 2), 4'hF, '0,
                 CHK_EQ, ram_model[word_idx[i]], 1'b0, rdata);
    end

    // unmapped address whose offset aliases a RAM word
    bus_access(1'b1, UNMAPPED_BASE | (word_idx[0] << 2), 4'hF, $random(seed),
               CHK_EQ, '0, 1'b1, rdata);
    bus_access(1'b0, UNMAPPED_BASE | (word_idx[0] << 2), 4'hF, '0, CHK_EQ, '0, 1'b1, rdata);
    bus_access(1'b0, `TILE_RAM_BASE | (word_idx[0] << 2), 4'hF, '0,
               CHK_EQ, ram_model[word_idx[0]], 1'b0, rdata);

    // mtime keeps counting
    bus_access(1'b0, MTIME_LO_ADDR, 4'hF, '0, CHK_NONE, '0, 1'b0, first_time);
    bus_access(1'b0, MTIME_LO_ADDR, 4'hF, '0, CHK_GT, first_time, 1'b0, rdata);
    // arm the compare a little ahead of now
    bus_access(1'b1, CMP_HI_ADDR, 4'hF, '0, CHK_EQ, '0, 1'b0, rdata);
    bus_access(1'b0, MTIME_LO_ADDR, 4'hF, '0, CHK_GT, first_time, 1'b0, now_time);
    irq_quiet = 1'b0;
    bus_access(1'b1, CMP_LO_ADDR, 4'hF, now_time + 32'd20, CHK_EQ, '0, 1'b0, rdata);
    wait_irq_level(1'b1, "timer interrupt did not rise after mtimecmp was armed");
    bus_access(1'b1, CMP_LO_ADDR, 4'hF, '1, CHK_EQ, '0, 1'b0, rdata);
    bus_access(1'b1, CMP_HI_ADDR, 4'hF, '1, CHK_EQ, '0, 1'b0, rdata);
    wait_irq_level(1'b0, "timer interrupt did not fall after mtimecmp went to all ones");
    irq_quiet = 1'b1;

    // character out, then reads of the write-only block
    wdata = $random(seed);
    exp_char = wdata[7:0];
    bus_access(1'b1, CHAR_ADDR, 4'hF, wdata, CHK_EQ, '0, 1'b0, rdata);
    bus_access(1'b0, CHAR_ADDR, 4'hF, '0, CHK_EQ, '0, 1'b0, rdata);
    bus_access(1'b0, HALT_ADDR, 4'hF, '0, CHK_EQ, '0, 1'b0, rdata);
    // halt, then more traffic while it must hold
    bus_access(1'b1, HALT_ADDR, 4'hF, 32'd1, CHK_EQ, '0, 1'b0, rdata);
    bus_access(1'b0, `TILE_RAM_BASE | (word_idx[1] << 2), 4'hF, '0,
               CHK_EQ, ram_model[word_idx[1]], 1'b0, rdata);
    bus_access(1'b0, MTIME_LO_ADDR, 4'hF, '0, CHK_GT, now_time, 1'b0, rdata);

    // let the last checks settle
    repeat (3) @(posedge clk_sys);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+src
src/tile_pkg.sv
src/bus_decoder.sv
src/data_ram.sv
src/mtimer.sv
src/sim_ctrl.sv
src/resp_router.sv
src/tile_bus_top.sv
tb/tile_bus_tb.sv

// ==== Bender.yml ====
package:
  name: tile_bus

sources:
  - include_dirs:
      - src
    files:
      - src/tile_pkg.sv
      - src/bus_decoder.sv
      - src/data_ram.sv
      - src/mtimer.sv
      - src/sim_ctrl.sv
      - src/resp_router.sv
      - src/tile_bus_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tile_bus_tb.sv
